// File: all.f
verilog/sdmacCpuPkg.sv
verilog/sdmacScsiPkg.sv
verilog/strobeTimer.sv
verilog/dmaFifo.sv
verilog/portDatapath.sv
verilog/scsiSm.sv
verilog/dmacRegisters.sv
verilog/sdmacTop.sv
verif/clkGen.sv
verif/tbSdmac.sv

// File: run.sh
#!/bin/sh
# Build and run the SDMAC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tbSdmac -o simSdmac

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/simSdmac

// File: verif/clkGen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk_o,
    output logic arstN_o
);

    initial clk_o = 1'b0;

    always #4 clk_o = ~clk_o;  // 8 ns period

    initial begin
        arstN_o <= 1'b0;
        repeat (10) @(posedge clk_o);
        arstN_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/sdmacTrace.txt
# op arg data (hex). W/R: CPU write or read of register arg, R expects data
# P/E: arg halfwords from data upward that the chip supplies or expects
# Q: wait until DMA is idle; I: drive intA with data bit 0
R 00 00000000
R 04 00000008
E 01 00005a5a
W 10 00005a5a
P 01 0000c3c3
R 10 0000c3c3
P 04 0000a100
W 00 00000002
R 00 00000002
Q 00 00000000
R 08 a100a101
R 08 a102a103
R 04 00000008
W 00 00000000
E 04 0000b200
W 00 00000006
R 00 00000006
W 08 b200b201
W 08 b202b203
Q 00 00000000
R 04 00000008
W 00 00000000
P 10 00001000
W 00 00000002
Q 00 00000000
R 04 00000004
P 02 00001010
R 08 10001001
Q 00 00000000
R 04 00000004
R 08 10021003
W 0c 00000000
R 04 00000008
W 00 00000000
I 00 00000001
R 04 00000008
W 00 00000001
R 04 0000000a
I 00 00000000
R 04 00000008
I 00 00000001
R 04 0000000a
W 00 00000000
R 04 00000008

// File: verif/tbSdmac.sv
// SDMAC testbench
`timescale 1ns/1ps
`default_nettype none

module tbSdmac;

    logic                       clk;
    logic                       arstN;
    sdmacCpuPkg::cpuReq_t       cpuReq;
    sdmacCpuPkg::cpuRsp_t       cpuRsp;
    sdmacScsiPkg::scsiPortIn_t  scsiIn;
    sdmacScsiPkg::scsiPortOut_t scsiOut;
    logic                       intO;
    logic [15:0]                chipPd;
    logic                       chipDreqN;
    logic                       intA;
    logic                       relayBusy = 1'b0;  // A relayed chip access is outstanding

    logic [7:0]  opList [$];
    logic [7:0]  argList [$];
    logic [31:0] dataList [$];
    logic [15:0] supplyQ [$];  // Halfwords the chip hands out on read strobes
    logic [15:0] expectQ [$];  // Halfwords the chip must see on write strobes
    integer      seed = 83;
    int          cycles = 0;
    int          limit = 0;

    assign scsiIn = '{pd: chipPd, dreqN: chipDreqN, intA: intA};

    clkGen uClk (.clk_o(clk), .arstN_o(arstN));

    sdmacTop dut0 (
        .sclk_i(clk), .arstN_i(arstN), .cpuReq_i(cpuReq), .cpuRsp_o(cpuRsp),
        .scsiIn_i(scsiIn), .scsiOut_o(scsiOut), .int_o(intO)
    );

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkLong(input sdmacScsiPkg::fifoWord_u got,
                             input sdmacScsiPkg::fifoWord_u exp, input string what);
        if (got !== exp)
            stopRun($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got.lword, exp.lword));
    endtask

    task automatic checkHalf(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp)
            stopRun($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic checkStatus(input sdmacCpuPkg::istr_t got, input sdmacCpuPkg::istr_t exp,
                               input string what);
        if (got !== exp)
            stopRun($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // One host access, returns once the ack pulse is seen
    task automatic cpuAccess(input logic rw, input logic [4:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge clk);
        relayBusy = (addr == sdmacCpuPkg::ADDR_SCSI);
        cpuReq <= '{sel: 1'b1, rw: rw, addr: addr, wdata: wdata};
        @(posedge clk);
        cpuReq.sel <= 1'b0;
        do begin
            @(posedge clk);
        end while (!cpuRsp.ack);
        rdata = cpuRsp.rdata;
        relayBusy = 1'b0;
    endtask

    task automatic checkRead(input logic [4:0] addr, input logic [31:0] rdata,
                             input logic [31:0] exp);
        sdmacCpuPkg::istr_t pin;
        case (addr)
            sdmacCpuPkg::ADDR_ISTR: begin
                checkStatus(sdmacCpuPkg::istr_t'(rdata[3:0]), sdmacCpuPkg::istr_t'(exp[3:0]),
                            "ISTR");
                pin = sdmacCpuPkg::istr_t'(exp[3:0]);
                pin.intPend = intO;  // Interrupt pin against the status bit
                checkStatus(pin, sdmacCpuPkg::istr_t'(exp[3:0]), "int_o");
                checkLong(sdmacScsiPkg::fifoWord_u'(rdata), sdmacScsiPkg::fifoWord_u'(exp),
                          "ISTR word");
            end
            sdmacCpuPkg::ADDR_SCSI: begin
                checkHalf(rdata[15:0], exp[15:0], "relayed chip read");
                checkHalf(rdata[31:16], 16'h0000, "upper half of relayed read");
            end
            default: begin
                checkLong(sdmacScsiPkg::fifoWord_u'(rdata), sdmacScsiPkg::fifoWord_u'(exp),
                          $sformatf("read of register %h", addr));
            end
        endcase
    endtask

    // Chip queues drained, then poll until DMA is idle
    task automatic waitIdle();
        logic [31:0]        rdata;
        sdmacCpuPkg::istr_t st;
        while (supplyQ.size() != 0 || expectQ.size() != 0) begin
            @(posedge clk);
        end
        do begin
            cpuAccess(1'b1, sdmacCpuPkg::ADDR_ISTR, 32'h0, rdata);
            st = sdmacCpuPkg::istr_t'(rdata[3:0]);
        end while (st.dmaBusy);
    endtask

    task automatic runOp(input logic [7:0] op, input logic [7:0] arg, input logic [31:0] data);
        logic [31:0] rdata;
        case (op)
            "W": cpuAccess(1'b0, arg[4:0], data, rdata);
            "R": begin
                cpuAccess(1'b1, arg[4:0], 32'h0, rdata);
                checkRead(arg[4:0], rdata, data);
            end
            "P": for (int k = 0; k < int'(arg); k++) supplyQ.push_back(data[15:0] + 16'(k));
            "E": for (int k = 0; k < int'(arg); k++) expectQ.push_back(data[15:0] + 16'(k));
            "Q": waitIdle();
            "I": begin
                @(posedge clk);
                intA <= data[0];
            end
            default: stopRun($sformatf("Unknown operation %c in the trace file", op));
        endcase
    endtask

    task automatic loadTrace();
        integer      fd;
        string       line;
        logic [7:0]  op;
        logic [7:0]  arg;
        logic [31:0] data;
        fd = $fopen("verif/sdmacTrace.txt", "r");
        if (fd == 0) begin
            stopRun("Could not open the trace file verif/sdmacTrace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 3 || line[0] == "#")
                    continue;  // Comments and blank lines
                if ($sscanf(line, "%c %h %h", op, arg, data) == 3) begin
                    opList.push_back(op);
                    argList.push_back(arg);
                    dataList.push_back(data);
                end
            end
            $fclose(fd);
        end
    endtask

    // Chip model, answers strobes and paces DMA with DREQ
    initial begin : chipModel
        logic        prevIorN;
        logic        prevIowN;
        logic [15:0] lastPd;
        logic        strobeOn;
        int          strobeLen;
        prevIorN  = 1'b1;
        prevIowN  = 1'b1;
        lastPd    = 16'h0000;
        strobeLen = 0;
        chipPd    <= 16'h0000;
        chipDreqN <= 1'b1;
        forever begin
            @(posedge clk);
            if (arstN) begin
                strobeOn = !scsiOut.iorN || !scsiOut.iowN;
                if (!scsiOut.csN && !scsiOut.dackN)
                    stopRun("Chip select and DMA acknowledge are active together");
                else if (strobeOn && scsiOut.csN && scsiOut.dackN)
                    stopRun("I/O strobe seen without chip select or DMA acknowledge");
                else if (strobeOn && relayBusy && scsiOut.csN)
                    stopRun("Relayed register access strobed without chip select");
                else if (strobeOn && !relayBusy && scsiOut.dackN)
                    stopRun("DMA strobe seen without DMA acknowledge");
                else if (!scsiOut.iowN && !scsiOut.pdOe)
                    stopRun("Write strobe seen while the data port is not driven");
                else if (!scsiOut.iorN && scsiOut.pdOe)
                    stopRun("Data port driven during a read strobe");
                else if (!scsiOut.iorN && supplyQ.size() == 0)
                    stopRun("Read strobe seen with no halfword queued for the chip");
                if (strobeOn)
                    strobeLen++;
                if (!scsiOut.iowN)
                    lastPd = scsiOut.pdOut;  // Last strobe clock wins
                if ((scsiOut.iorN && !prevIorN) || (scsiOut.iowN && !prevIowN)) begin
                    if (strobeLen != sdmacScsiPkg::STROBE_CYCLES)
                        stopRun($sformatf("I/O strobe lasted %0d clocks", strobeLen));
                    strobeLen = 0;
                end
                if (scsiOut.iorN && !prevIorN)
                    void'(supplyQ.pop_front());
                if (scsiOut.iowN && !prevIowN) begin
                    if (expectQ.size() == 0)
                        stopRun("Write strobe seen with no halfword expected by the chip");
                    else
                        checkHalf(lastPd, expectQ.pop_front(), "halfword written to chip");
                end
                prevIorN = scsiOut.iorN;
                prevIowN = scsiOut.iowN;
                chipPd <= (supplyQ.size() != 0) ? supplyQ[0] : 16'h0000;
                chipDreqN <= ~(((supplyQ.size() != 0) || (expectQ.size() != 0)) &&
                               (($random(seed) & 3) != 0));  // Drops out now and then
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit)
            stopRun($sformatf("The run timed out after %0d cycles", cycles));
    end

    initial begin
        int gap;
        cpuReq <= '0;
        intA   <= 1'b0;
        loadTrace();
        limit = 64 * opList.size() + 20;
        @(posedge arstN);
        @(posedge clk);
        checkHalf({11'b0, scsiOut.csN, scsiOut.iorN, scsiOut.iowN, scsiOut.dackN,
                   scsiOut.pdOe}, 16'h001e, "port strobes after reset");
        for (int i = 0; i < opList.size(); i++) begin
            gap = $random(seed) & 3;  // Idle gap between operations
            repeat (gap) @(posedge clk);
            runOp(opList[i], argList[i], dataList[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dmaFifo.sv
// DMA longword FIFO
`timescale 1ns/1ps
`default_nettype none

module dmaFifo (
    input  wire                     sclk_i,
    input  wire                     arstN_i,
    input  wire                     push_i,
    input  wire                     pop_i,
    input  wire                     flush_i,
    input  sdmacScsiPkg::fifoWord_u wdata_i,
    output sdmacScsiPkg::fifoWord_u rdata_o,
    output logic                    full_o,
    output logic                    empty_o
);

    sdmacScsiPkg::fifoWord_u mem [sdmacScsiPkg::FIFO_DEPTH];

    logic [$clog2(sdmacScsiPkg::FIFO_DEPTH)-1:0] wrPtr;
    logic [$clog2(sdmacScsiPkg::FIFO_DEPTH)-1:0] rdPtr;
    logic [$clog2(sdmacScsiPkg::FIFO_DEPTH):0]   count;
    logic                                        doPush;
    logic                                        doPop;

    assign full_o  = (count == ($clog2(sdmacScsiPkg::FIFO_DEPTH) + 1)'(sdmacScsiPkg::FIFO_DEPTH));
    assign empty_o = (count == '0);

    // Writes to a full FIFO are dropped, pops of an empty one ignored
    assign doPush = push_i & ~full_o & ~flush_i;
    assign doPop  = pop_i & ~empty_o & ~flush_i;

    always_ff @(posedge sclk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps with the power-of-two depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sclk_i) begin
        if (doPush) begin
            mem[wrPtr] <= wdata_i;
        end
    end

    assign rdata_o = mem[rdPtr];  // Look-ahead head

endmodule

`default_nettype wire

// File: verilog/dmacRegisters.sv
// DMAC host register file
`timescale 1ns/1ps
`default_nettype none

module dmacRegisters (
    input  wire                     sclk_i,
    input  wire                     arstN_i,
    input  sdmacCpuPkg::cpuReq_t    cpuReq_i,
    output sdmacCpuPkg::cpuRsp_t    cpuRsp_o,
    input  wire                     intA_i,
    input  wire                     fifoEmpty_i,
    input  wire                     fifoFull_i,
    input  wire                     dmaBusy_i,
    input  sdmacScsiPkg::fifoWord_u fifoRdata_i,
    input  wire  [15:0]             relayRdata_i,
    input  wire                     relayDone_i,
    output sdmacCpuPkg::cntrReg_t   cntr_o,
    output logic                    relayReq_o,
    output logic                    relayRw_o,
    output logic [15:0]             relayWdata_o,
    output logic                    fifoPush_o,
    output logic                    fifoPop_o,
    output sdmacScsiPkg::fifoWord_u fifoWdata_o,
    output logic                    flush_o,
    output logic                    int_o
);

    sdmacCpuPkg::cntrReg_t cntrQ;
    sdmacCpuPkg::istr_t    istr;
    logic                  ackQ;
    logic [31:0]           rdataQ;
    logic                  relayReqQ;
    logic                  intQ;
    logic                  isScsi;
    logic [31:0]           rdNext;

    assign isScsi = (cpuReq_i.addr == sdmacCpuPkg::ADDR_SCSI);

    assign istr = '{fifoEmpty: fifoEmpty_i, fifoFull: fifoFull_i,
                    intPend: intQ, dmaBusy: dmaBusy_i};

    // Read data for the local registers
    always_comb begin
        case (cpuReq_i.addr)
            sdmacCpuPkg::ADDR_CNTR: rdNext = {29'b0, cntrQ};
            sdmacCpuPkg::ADDR_ISTR: rdNext = {28'b0, istr};
            sdmacCpuPkg::ADDR_FIFO: rdNext = fifoEmpty_i ? 32'b0 : fifoRdata_i.lword;
            default:                rdNext = 32'b0;
        endcase
    end

    // FIFO and flush act in the select cycle
    assign fifoPush_o = cpuReq_i.sel & ~cpuReq_i.rw &
                        (cpuReq_i.addr == sdmacCpuPkg::ADDR_FIFO);
    assign fifoPop_o  = cpuReq_i.sel & cpuReq_i.rw & ~fifoEmpty_i &
                        (cpuReq_i.addr == sdmacCpuPkg::ADDR_FIFO);
    assign flush_o    = cpuReq_i.sel & ~cpuReq_i.rw &
                        (cpuReq_i.addr == sdmacCpuPkg::ADDR_FLUSH);
    assign fifoWdata_o.lword = cpuReq_i.wdata;

    always_ff @(posedge sclk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            cntrQ     <= '0;
            ackQ      <= 1'b0;
            relayReqQ <= 1'b0;
            intQ      <= 1'b0;
        end else begin
            ackQ <= relayDone_i | (cpuReq_i.sel & ~isScsi);
            if (cpuReq_i.sel && isScsi) begin
                relayReqQ <= 1'b1;  // Held until the chip cycle ends
            end else if (relayDone_i) begin
                relayReqQ <= 1'b0;
            end
            if (cpuReq_i.sel && !cpuReq_i.rw && cpuReq_i.addr == sdmacCpuPkg::ADDR_CNTR) begin
                cntrQ <= sdmacCpuPkg::cntrReg_t'(cpuReq_i.wdata[2:0]);
            end
            intQ <= cntrQ.intEna & intA_i;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (relayDone_i) begin
            rdataQ <= relayRw_o ? {16'b0, relayRdata_i} : 32'b0;
        end else if (cpuReq_i.sel) begin
            rdataQ <= rdNext;
        end
        if (cpuReq_i.sel && isScsi) begin
            relayRw_o    <= cpuReq_i.rw;
            relayWdata_o <= cpuReq_i.wdata[15:0];
        end
    end

    assign cpuRsp_o.ack   = ackQ;
    assign cpuRsp_o.rdata = rdataQ;
    assign cntr_o         = cntrQ;
    assign relayReq_o     = relayReqQ;
    assign int_o          = intQ;

endmodule

`default_nettype wire

// File: verilog/portDatapath.sv
// Peripheral port datapath
`timescale 1ns/1ps
`default_nettype none

module portDatapath (
    input  wire                     sclk_i,
    input  wire                     arstN_i,
    input  wire  [15:0]             pd_i,
    input  wire                     captureHalf_i,  // Last strobe clock of a read
    input  wire                     halfSel_i,      // 0 = hi halfword
    input  wire                     relayActive_i,
    input  wire  [15:0]             relayWdata_i,
    input  sdmacScsiPkg::fifoWord_u fifoHead_i,
    output sdmacScsiPkg::fifoWord_u packed_o,
    output logic [15:0]             pdOut_o,
    output logic [15:0]             relayRdata_o
);

    sdmacScsiPkg::fifoWord_u packReg;
    logic [15:0]             relayLatch;

    // Read halfwords go to the relay latch or into the packing register
    always_ff @(posedge sclk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            packReg    <= '0;
            relayLatch <= '0;
        end else if (captureHalf_i) begin
            if (relayActive_i) begin
                relayLatch <= pd_i;
            end else if (halfSel_i) begin
                packReg.half.loHalf <= pd_i;  // Completes the longword
            end else begin
                packReg.half.hiHalf <= pd_i;
            end
        end
    end

    // Outgoing halfword
    always_comb begin
        if (relayActive_i) begin
            pdOut_o = relayWdata_i;
        end else if (halfSel_i) begin
            pdOut_o = fifoHead_i.half.loHalf;
        end else begin
            pdOut_o = fifoHead_i.half.hiHalf;  // Hi goes out first
        end
    end

    assign packed_o     = packReg;
    assign relayRdata_o = relayLatch;

endmodule

`default_nettype wire

// File: verilog/scsiSm.sv
// SCSI peripheral cycle FSM
`timescale 1ns/1ps
`default_nettype none

module scsiSm (
    input  wire                        sclk_i,
    input  wire                        arstN_i,
    input  sdmacCpuPkg::cntrReg_t      cntr_i,
    input  wire                        dreqN_i,
    input  wire                        fifoEmpty_i,
    input  wire                        fifoFull_i,
    input  wire                        relayReq_i,
    input  wire                        relayRw_i,
    input  wire                        phaseDone_i,
    output logic                       timerStart_o,
    output sdmacScsiPkg::phase_e       phase_o,
    output logic                       relayDone_o,
    output logic                       halfSel_o,
    output logic                       captureHalf_o,
    output logic                       fifoPush_o,
    output logic                       fifoPop_o,
    output logic                       dmaBusy_o,
    output sdmacScsiPkg::scsiPortOut_t portCtl_o
);

    sdmacScsiPkg::phase_e phaseQ;
    logic                 isRelayQ;  // Current cycle is a relayed register access
    logic                 isReadQ;   // Current cycle reads the chip
    logic                 startQ;
    logic                 halfSelQ;
    logic                 dmaGo;
    logic                 cycleEnd;
    logic                 active;

    // DMA may start only with room for the data
    assign dmaGo = cntr_i.dmaEna & ~dreqN_i &
                   (cntr_i.dmaDir ? ~fifoEmpty_i : ~fifoFull_i);

    assign cycleEnd = (phaseQ == sdmacScsiPkg::RECOV) & phaseDone_i;
    assign active   = (phaseQ != sdmacScsiPkg::IDLE);

    always_ff @(posedge sclk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            phaseQ   <= sdmacScsiPkg::IDLE;
            isRelayQ <= 1'b0;
            isReadQ  <= 1'b0;
            startQ   <= 1'b0;
            halfSelQ <= 1'b0;
        end else begin
            startQ <= 1'b0;
            case (phaseQ)
                sdmacScsiPkg::IDLE: begin
                    if (relayReq_i) begin  // Relay wins over DMA
                        phaseQ   <= sdmacScsiPkg::SETUP;
                        isRelayQ <= 1'b1;
                        isReadQ  <= relayRw_i;
                        startQ   <= 1'b1;
                    end else if (dmaGo) begin
                        phaseQ   <= sdmacScsiPkg::SETUP;
                        isRelayQ <= 1'b0;
                        isReadQ  <= ~cntr_i.dmaDir;
                        startQ   <= 1'b1;
                    end
                end
                sdmacScsiPkg::SETUP: begin
                    if (phaseDone_i) begin
                        phaseQ <= sdmacScsiPkg::STROBE;
                        startQ <= 1'b1;
                    end
                end
                sdmacScsiPkg::STROBE: begin
                    if (phaseDone_i) begin
                        phaseQ <= sdmacScsiPkg::RECOV;
                        startQ <= 1'b1;
                    end
                end
                default: begin
                    if (phaseDone_i) begin
                        phaseQ <= sdmacScsiPkg::IDLE;
                        if (!isRelayQ) begin
                            halfSelQ <= ~halfSelQ;  // Next halfword of the pair
                        end
                    end
                end
            endcase
        end
    end

    assign timerStart_o  = startQ;
    assign phase_o       = phaseQ;
    assign halfSel_o     = halfSelQ;
    assign relayDone_o   = cycleEnd & isRelayQ;
    assign captureHalf_o = (phaseQ == sdmacScsiPkg::STROBE) & phaseDone_i & isReadQ;
    assign fifoPush_o    = cycleEnd & ~isRelayQ & halfSelQ & isReadQ;   // Lo half captured
    assign fifoPop_o     = cycleEnd & ~isRelayQ & halfSelQ & ~isReadQ;  // Lo half sent
    assign dmaBusy_o     = active & ~isRelayQ;

    // Strobes, all active low
    assign portCtl_o.csN   = ~(active & isRelayQ);
    assign portCtl_o.dackN = ~(active & ~isRelayQ);
    assign portCtl_o.iorN  = ~((phaseQ == sdmacScsiPkg::STROBE) & isReadQ);
    assign portCtl_o.iowN  = ~((phaseQ == sdmacScsiPkg::STROBE) & ~isReadQ);
    assign portCtl_o.pdOe  = active & ~isReadQ;
    assign portCtl_o.pdOut = '0;  // Supplied by the datapath

endmodule

`default_nettype wire

// File: verilog/sdmacCpuPkg.sv
// SDMAC host register map
`default_nettype none

package sdmacCpuPkg;

    // Register offsets within the 5-bit host address
    localparam logic [4:0] ADDR_CNTR  = 5'h00;
    localparam logic [4:0] ADDR_ISTR  = 5'h04;
    localparam logic [4:0] ADDR_FIFO  = 5'h08;
    localparam logic [4:0] ADDR_FLUSH = 5'h0C;
    localparam logic [4:0] ADDR_SCSI  = 5'h10;  // Relayed to the SCSI chip

    typedef struct packed {
        logic        sel;    // One-cycle access strobe
        logic        rw;     // 1 = read
        logic [4:0]  addr;
        logic [31:0] wdata;
    } cpuReq_t;

    typedef struct packed {
        logic        ack;    // Single-cycle pulse, rdata valid with it
        logic [31:0] rdata;
    } cpuRsp_t;

    typedef struct packed {
        logic dmaDir;        // 0 = SCSI to FIFO
        logic dmaEna;
        logic intEna;
    } cntrReg_t;

    // Low nibble of the ISTR read
    typedef struct packed {
        logic fifoEmpty;
        logic fifoFull;
        logic intPend;
        logic dmaBusy;
    } istr_t;

endpackage

`default_nettype wire

// File: verilog/sdmacScsiPkg.sv
// SCSI peripheral port definitions
`default_nettype none

package sdmacScsiPkg;

    // Peripheral cycle phase lengths in clocks
    localparam int SETUP_CYCLES  = 1;
    localparam int STROBE_CYCLES = 3;
    localparam int RECOV_CYCLES  = 1;

    localparam int FIFO_DEPTH = 8;  // Longwords, power of two

    typedef struct packed {
        logic        csN;    // Chip register select
        logic        iorN;
        logic        iowN;
        logic        dackN;  // DMA acknowledge
        logic        pdOe;   // Drive the data port
        logic [15:0] pdOut;
    } scsiPortOut_t;

    typedef struct packed {
        logic [15:0] pd;
        logic        dreqN;
        logic        intA;
    } scsiPortIn_t;

    // FIFO side sees a longword, the port side sees two halfwords
    typedef union packed {
        logic [31:0] lword;
        struct packed {
            logic [15:0] hiHalf;
            logic [15:0] loHalf;
        } half;
    } fifoWord_u;

    typedef enum logic [1:0] {IDLE, SETUP, STROBE, RECOV} phase_e;

endpackage

`default_nettype wire

// File: verilog/sdmacTop.sv
// SDMAC top level
`timescale 1ns/1ps
`default_nettype none

module sdmacTop (
    input  wire                        sclk_i,
    input  wire                        arstN_i,
    input  sdmacCpuPkg::cpuReq_t       cpuReq_i,
    output sdmacCpuPkg::cpuRsp_t       cpuRsp_o,
    input  sdmacScsiPkg::scsiPortIn_t  scsiIn_i,
    output sdmacScsiPkg::scsiPortOut_t scsiOut_o,
    output logic                       int_o
);

    sdmacCpuPkg::cntrReg_t      cntr;
    sdmacScsiPkg::scsiPortOut_t portCtl;
    sdmacScsiPkg::phase_e       phase;
    sdmacScsiPkg::fifoWord_u    cpuWdata, packedWord, fifoHead, fifoWdata;
    logic        relayReq, relayRw, relayDone;
    logic [15:0] relayWdata, relayRdata, pdOut;
    logic        cpuPush, cpuPop, smPush, smPop, flush;
    logic        fifoFull, fifoEmpty, dmaBusy;
    logic        timerStart, phaseDone, halfSel, captureHalf;

    // Both sides share the FIFO ports, simultaneous use is a host error
    assign fifoWdata = smPush ? packedWord : cpuWdata;

    always_comb begin
        scsiOut_o       = portCtl;
        scsiOut_o.pdOut = pdOut;
    end

    dmacRegisters uRegs (
        .sclk_i(sclk_i), .arstN_i(arstN_i), .cpuReq_i(cpuReq_i), .cpuRsp_o(cpuRsp_o),
        .intA_i(scsiIn_i.intA), .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull),
        .dmaBusy_i(dmaBusy), .fifoRdata_i(fifoHead), .relayRdata_i(relayRdata),
        .relayDone_i(relayDone), .cntr_o(cntr), .relayReq_o(relayReq),
        .relayRw_o(relayRw), .relayWdata_o(relayWdata), .fifoPush_o(cpuPush),
        .fifoPop_o(cpuPop), .fifoWdata_o(cpuWdata), .flush_o(flush), .int_o(int_o)
    );

    scsiSm uScsiSm (
        .sclk_i(sclk_i), .arstN_i(arstN_i), .cntr_i(cntr), .dreqN_i(scsiIn_i.dreqN),
        .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull), .relayReq_i(relayReq),
        .relayRw_i(relayRw), .phaseDone_i(phaseDone), .timerStart_o(timerStart),
        .phase_o(phase), .relayDone_o(relayDone), .halfSel_o(halfSel),
        .captureHalf_o(captureHalf), .fifoPush_o(smPush), .fifoPop_o(smPop),
        .dmaBusy_o(dmaBusy), .portCtl_o(portCtl)
    );

    strobeTimer uTimer (
        .sclk_i(sclk_i), .arstN_i(arstN_i), .start_i(timerStart), .phase_i(phase),
        .phaseDone_o(phaseDone)
    );

    dmaFifo uFifo (
        .sclk_i(sclk_i), .arstN_i(arstN_i), .push_i(cpuPush | smPush),
        .pop_i(cpuPop | smPop), .flush_i(flush), .wdata_i(fifoWdata),
        .rdata_o(fifoHead), .full_o(fifoFull), .empty_o(fifoEmpty)
    );

    portDatapath uDatapath (
        .sclk_i(sclk_i), .arstN_i(arstN_i), .pd_i(scsiIn_i.pd),
        .captureHalf_i(captureHalf), .halfSel_i(halfSel), .relayActive_i(~portCtl.csN),
        .relayWdata_i(relayWdata), .fifoHead_i(fifoHead), .packed_o(packedWord),
        .pdOut_o(pdOut), .relayRdata_o(relayRdata)
    );

endmodule

`default_nettype wire

// File: verilog/strobeTimer.sv
// Peripheral phase timer
`timescale 1ns/1ps
`default_nettype none

module strobeTimer (
    input  wire                  sclk_i,
    input  wire                  arstN_i,
    input  wire                  start_i,   // First clock of a phase
    input  sdmacScsiPkg::phase_e phase_i,
    output logic                 phaseDone_o
);

    logic [2:0] cnt;
    logic [2:0] phaseLen;

    always_comb begin
        case (phase_i)
            sdmacScsiPkg::SETUP:  phaseLen = 3'(sdmacScsiPkg::SETUP_CYCLES);
            sdmacScsiPkg::STROBE: phaseLen = 3'(sdmacScsiPkg::STROBE_CYCLES);
            sdmacScsiPkg::RECOV:  phaseLen = 3'(sdmacScsiPkg::RECOV_CYCLES);
            default:              phaseLen = 3'd1;
        endcase
    end

    always_ff @(posedge sclk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            cnt <= '0;
        end else if (start_i) begin
            cnt <= phaseLen - 3'd1;  // Start clock already counts
        end else if (cnt != 3'd0) begin
            cnt <= cnt - 3'd1;
        end
    end

    // Done in the last clock of the phase
    assign phaseDone_o = start_i ? (phaseLen == 3'd1) : (cnt == 3'd1);

endmodule

`default_nettype wire
